// ==== cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

	// tile geometry
	localparam int img_rows = 8;
	localparam int img_cols = 8;
	localparam int kernel_dim = 3;
	localparam int num_taps = kernel_dim * kernel_dim;
	localparam int out_rows = img_rows - kernel_dim + 1;
	localparam int out_cols = img_cols - kernel_dim + 1;
	localparam int pos_w = $clog2(img_cols);

	localparam int num_filters = 4;
	localparam int filt_w = $clog2(num_filters);
	localparam int num_channels = 4;
	localparam int chan_w = $clog2(num_channels);

	// row r sits in bank r mod 3, three rows of img_cols per bank
	localparam int num_banks = kernel_dim;
	localparam int rows_per_bank = (img_rows + num_banks - 1) / num_banks;
	localparam int in_addr_w = $clog2(rows_per_bank * img_cols);

	localparam int pix_w = 16;
	localparam int psum_w = 32;
	localparam int wt_addr_w = $clog2(num_channels * num_filters);
	localparam int wt_word_w = num_taps * pix_w;
	localparam int out_addr_w = $clog2(out_rows * out_cols);
	localparam int out_word_w = num_filters * psum_w;

	// step to output write, in cycles
	localparam int pipe_depth = 5;

	// scan_control states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_load = 2'd1;
	localparam logic [1:0] st_sweep = 2'd2;
	localparam logic [1:0] st_drain = 2'd3;

endpackage

`default_nettype wire

// ==== scan_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_control (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic weights_ready,
	output logic ack,
	output logic wload_start,
	output logic step_valid,
	output logic [cnn_pkg::pos_w-1:0] step_row,
	output logic [cnn_pkg::pos_w-1:0] step_col,
	output logic step_emit,
	output logic [cnn_pkg::out_addr_w-1:0] step_out_addr
);

	logic [1:0] state;
	logic [cnn_pkg::pos_w-1:0] row_cnt;
	logic [cnn_pkg::pos_w-1:0] col_cnt;
	logic [2:0] drain_cnt;
	logic [cnn_pkg::out_addr_w-1:0] out_cnt;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			state <= cnn_pkg::st_idle;
			ack <= 1'b0;
			wload_start <= 1'b0;
			row_cnt <= '0;
			col_cnt <= '0;
			drain_cnt <= '0;
			out_cnt <= '0;
		end
		else
		begin
			wload_start <= 1'b0;
			case (state)
				cnn_pkg::st_idle:
				begin
					if (req)
					begin
						state <= cnn_pkg::st_load;
						wload_start <= 1'b1;
					end
				end
				cnn_pkg::st_load:
				begin
					row_cnt <= '0;
					col_cnt <= '0;
					out_cnt <= '0;
					// ready is still stale while the start pulse is out
					if (weights_ready && !wload_start)
						state <= cnn_pkg::st_sweep;
				end
				cnn_pkg::st_sweep:
				begin
					if (step_emit)
						out_cnt <= out_cnt + 1'b1;
					if (col_cnt == cnn_pkg::img_cols - 1)
					begin
						col_cnt <= '0;
						if (row_cnt == cnn_pkg::out_rows - 1)
						begin
							state <= cnn_pkg::st_drain;
							drain_cnt <= '0;
						end
						else
							row_cnt <= row_cnt + 1'b1;
					end
					else
						col_cnt <= col_cnt + 1'b1;
				end
				default:
				begin
					// wait out the pipeline, then hold ack until req drops
					if (ack)
					begin
						if (!req)
						begin
							ack <= 1'b0;
							state <= cnn_pkg::st_idle;
						end
					end
					else if (drain_cnt == cnn_pkg::pipe_depth - 1)
						ack <= 1'b1;
					else
						drain_cnt <= drain_cnt + 1'b1;
				end
			endcase
		end
	end

	assign step_valid = (state == cnn_pkg::st_sweep);
	assign step_row = row_cnt;
	assign step_col = col_cnt;
	// full window only from the third column on
	assign step_emit = (col_cnt >= cnn_pkg::kernel_dim - 1);
	// emitted positions come out in raster order
	assign step_out_addr = out_cnt;

endmodule

`default_nettype wire

// ==== window_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_fetch (
	input  logic clk,
	input  logic rst,
	input  logic step_valid,
	input  logic [cnn_pkg::pos_w-1:0] step_row,
	input  logic [cnn_pkg::pos_w-1:0] step_col,
	input  logic step_emit,
	input  logic [cnn_pkg::out_addr_w-1:0] step_out_addr,
	input  logic [cnn_pkg::num_banks-1:0][cnn_pkg::pix_w-1:0] in_rd_data,
	output logic in_rd_en,
	output logic [cnn_pkg::num_banks-1:0][cnn_pkg::in_addr_w-1:0] in_addr,
	output logic win_valid,
	output logic [cnn_pkg::num_taps-1:0][cnn_pkg::pix_w-1:0] win_pixels,
	output logic [cnn_pkg::out_addr_w-1:0] win_out_addr
);

	logic [cnn_pkg::num_banks-1:0][cnn_pkg::in_addr_w-1:0] addr_next;
	logic [1:0] rot_s;
	logic [1:0] rot_a;
	logic [1:0] rot_b;
	logic emit_a;
	logic emit_b;
	logic valid_b;
	logic [cnn_pkg::out_addr_w-1:0] oaddr_a;
	logic [cnn_pkg::out_addr_w-1:0] oaddr_b;
	logic [cnn_pkg::kernel_dim-1:0][cnn_pkg::pix_w-1:0] new_col;

	// bank holding the window's top row
	assign rot_s = 2'(step_row % 3'(cnn_pkg::num_banks));

	// rows r, r+1, r+2 land in three different banks
	always_comb
	begin
		logic [cnn_pkg::pos_w-1:0] row;
		logic [cnn_pkg::pos_w-1:0] bank;
		logic [cnn_pkg::pos_w-1:0] slot;
		addr_next = '0;
		for (int k = 0; k < cnn_pkg::kernel_dim; k++)
		begin
			row = step_row + k[cnn_pkg::pos_w-1:0];
			bank = row % 3'(cnn_pkg::num_banks);
			slot = row / 3'(cnn_pkg::num_banks);
			addr_next[bank[1:0]] = {slot[1:0], step_col};
		end
	end

	// undo the rotation so window row 0 is the top row
	always_comb
	begin
		logic [2:0] idx;
		for (int k = 0; k < cnn_pkg::kernel_dim; k++)
		begin
			idx = {1'b0, rot_b} + k[2:0];
			if (idx >= 3'(cnn_pkg::num_banks))
				idx = idx - 3'(cnn_pkg::num_banks);
			new_col[k] = in_rd_data[idx[1:0]];
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			in_rd_en <= 1'b0;
			emit_a <= 1'b0;
			valid_b <= 1'b0;
			emit_b <= 1'b0;
			win_valid <= 1'b0;
		end
		else
		begin
			in_rd_en <= step_valid;
			emit_a <= step_valid & step_emit;
			valid_b <= in_rd_en;
			emit_b <= emit_a;
			win_valid <= emit_b;
		end
	end

	always_ff @(posedge clk)
	begin
		in_addr <= addr_next;
		rot_a <= rot_s;
		rot_b <= rot_a;
		oaddr_a <= step_out_addr;
		oaddr_b <= oaddr_a;
		win_out_addr <= oaddr_b;
		if (valid_b)
		begin
			// shift left, new column enters on the right
			for (int k = 0; k < cnn_pkg::kernel_dim; k++)
			begin
				for (int j = 0; j < cnn_pkg::kernel_dim - 1; j++)
					win_pixels[k * cnn_pkg::kernel_dim + j] <=
						win_pixels[k * cnn_pkg::kernel_dim + j + 1];
				win_pixels[k * cnn_pkg::kernel_dim + cnn_pkg::kernel_dim - 1] <= new_col[k];
			end
		end
	end

endmodule

`default_nettype wire

// ==== weight_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module weight_fetch (
	input  logic clk,
	input  logic rst,
	input  logic wload_start,
	input  logic [cnn_pkg::chan_w-1:0] channel,
	input  logic [cnn_pkg::wt_word_w-1:0] wt_rd_data,
	output logic wt_rd_en,
	output logic [cnn_pkg::wt_addr_w-1:0] wt_addr,
	output logic weights_ready,
	output logic [cnn_pkg::num_filters-1:0][cnn_pkg::wt_word_w-1:0] weights
);

	logic [cnn_pkg::filt_w-1:0] issue_cnt;
	logic [cnn_pkg::filt_w-1:0] cap_idx;
	logic cap_en;

	// filter f of channel c sits at c * num_filters + f
	assign wt_addr = {channel, issue_cnt};

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			wt_rd_en <= 1'b0;
			issue_cnt <= '0;
			cap_en <= 1'b0;
			cap_idx <= '0;
			weights_ready <= 1'b0;
		end
		else
		begin
			cap_en <= wt_rd_en;
			cap_idx <= issue_cnt;
			if (cap_en && cap_idx == cnn_pkg::num_filters - 1)
				weights_ready <= 1'b1;
			if (wload_start)
			begin
				wt_rd_en <= 1'b1;
				issue_cnt <= '0;
				weights_ready <= 1'b0;
			end
			else if (wt_rd_en)
			begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_cnt == cnn_pkg::num_filters - 1)
					wt_rd_en <= 1'b0;
			end
		end
	end

	// read data shows up one cycle behind the enable
	always_ff @(posedge clk)
	begin
		if (cap_en)
			weights[cap_idx] <= wt_rd_data;
	end

endmodule

`default_nettype wire

// ==== mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_array (
	input  logic clk,
	input  logic rst,
	input  logic [cnn_pkg::chan_w-1:0] channel,
	input  logic win_valid,
	input  logic [cnn_pkg::num_taps-1:0][cnn_pkg::pix_w-1:0] win_pixels,
	input  logic [cnn_pkg::out_addr_w-1:0] win_out_addr,
	input  logic [cnn_pkg::num_filters-1:0][cnn_pkg::wt_word_w-1:0] weights,
	input  logic [cnn_pkg::out_word_w-1:0] out_rd_data,
	output logic out_rd_en,
	output logic [cnn_pkg::out_addr_w-1:0] out_rd_addr,
	output logic out_wr_en,
	output logic [cnn_pkg::out_addr_w-1:0] out_wr_addr,
	output logic [cnn_pkg::out_word_w-1:0] out_wr_data
);

	logic signed [cnn_pkg::psum_w-1:0] dot [cnn_pkg::num_filters];
	logic signed [cnn_pkg::psum_w-1:0] sum_a [cnn_pkg::num_filters];
	logic signed [cnn_pkg::psum_w-1:0] sum_b [cnn_pkg::num_filters];

	// nine taps per filter, tap 0 in the top bits of the weight word
	always_comb
	begin
		logic signed [cnn_pkg::psum_w-1:0] acc;
		logic signed [cnn_pkg::pix_w-1:0] pix;
		logic signed [cnn_pkg::pix_w-1:0] wt;
		for (int f = 0; f < cnn_pkg::num_filters; f++)
		begin
			acc = '0;
			for (int t = 0; t < cnn_pkg::num_taps; t++)
			begin
				pix = win_pixels[t];
				wt = weights[f][(cnn_pkg::num_taps - 1 - t) * cnn_pkg::pix_w +: cnn_pkg::pix_w];
				acc = acc + pix * wt;
			end
			dot[f] = acc;
		end
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			out_rd_en <= 1'b0;
			out_wr_en <= 1'b0;
		end
		else
		begin
			out_rd_en <= win_valid;
			out_wr_en <= out_rd_en;
		end
	end

	// sums wait one cycle for the old partial sums
	always_ff @(posedge clk)
	begin
		out_rd_addr <= win_out_addr;
		out_wr_addr <= out_rd_addr;
		sum_a <= dot;
		sum_b <= sum_a;
	end

	// first channel starts from zero instead of the stored value
	always_comb
	begin
		logic signed [cnn_pkg::psum_w-1:0] prev;
		for (int f = 0; f < cnn_pkg::num_filters; f++)
		begin
			if (channel == '0)
				prev = '0;
			else
				prev = out_rd_data[f * cnn_pkg::psum_w +: cnn_pkg::psum_w];
			out_wr_data[f * cnn_pkg::psum_w +: cnn_pkg::psum_w] = sum_b[f] + prev;
		end
	end

endmodule

`default_nettype wire

// ==== conv_tile_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_tile_top (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic [cnn_pkg::chan_w-1:0] channel,
	input  logic [cnn_pkg::num_banks-1:0][cnn_pkg::pix_w-1:0] in_rd_data,
	input  logic [cnn_pkg::wt_word_w-1:0] wt_rd_data,
	input  logic [cnn_pkg::out_word_w-1:0] out_rd_data,
	output logic ack,
	output logic in_rd_en,
	output logic [cnn_pkg::num_banks-1:0][cnn_pkg::in_addr_w-1:0] in_addr,
	output logic wt_rd_en,
	output logic [cnn_pkg::wt_addr_w-1:0] wt_addr,
	output logic out_rd_en,
	output logic [cnn_pkg::out_addr_w-1:0] out_rd_addr,
	output logic out_wr_en,
	output logic [cnn_pkg::out_addr_w-1:0] out_wr_addr,
	output logic [cnn_pkg::out_word_w-1:0] out_wr_data
);

	logic wload_start;
	logic weights_ready;
	logic [cnn_pkg::num_filters-1:0][cnn_pkg::wt_word_w-1:0] weights;
	logic step_valid;
	logic [cnn_pkg::pos_w-1:0] step_row;
	logic [cnn_pkg::pos_w-1:0] step_col;
	logic step_emit;
	logic [cnn_pkg::out_addr_w-1:0] step_out_addr;
	logic win_valid;
	logic [cnn_pkg::num_taps-1:0][cnn_pkg::pix_w-1:0] win_pixels;
	logic [cnn_pkg::out_addr_w-1:0] win_out_addr;

	scan_control i_scan_control (
		.clk(clk),
		.rst(rst),
		.req(req),
		.weights_ready(weights_ready),
		.ack(ack),
		.wload_start(wload_start),
		.step_valid(step_valid),
		.step_row(step_row),
		.step_col(step_col),
		.step_emit(step_emit),
		.step_out_addr(step_out_addr)
	);

	window_fetch i_window_fetch (
		.clk(clk),
		.rst(rst),
		.step_valid(step_valid),
		.step_row(step_row),
		.step_col(step_col),
		.step_emit(step_emit),
		.step_out_addr(step_out_addr),
		.in_rd_data(in_rd_data),
		.in_rd_en(in_rd_en),
		.in_addr(in_addr),
		.win_valid(win_valid),
		.win_pixels(win_pixels),
		.win_out_addr(win_out_addr)
	);

	weight_fetch i_weight_fetch (
		.clk(clk),
		.rst(rst),
		.wload_start(wload_start),
		.channel(channel),
		.wt_rd_data(wt_rd_data),
		.wt_rd_en(wt_rd_en),
		.wt_addr(wt_addr),
		.weights_ready(weights_ready),
		.weights(weights)
	);

	mac_array i_mac_array (
		.clk(clk),
		.rst(rst),
		.channel(channel),
		.win_valid(win_valid),
		.win_pixels(win_pixels),
		.win_out_addr(win_out_addr),
		.weights(weights),
		.out_rd_data(out_rd_data),
		.out_rd_en(out_rd_en),
		.out_rd_addr(out_rd_addr),
		.out_wr_en(out_wr_en),
		.out_wr_addr(out_wr_addr),
		.out_wr_data(out_wr_data)
	);

endmodule

`default_nettype wire

// ==== tb_conv_tile.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_conv_tile;

	localparam int num_pos = cnn_pkg::out_rows * cnn_pkg::out_cols;
	localparam int pass_cycles = cnn_pkg::num_filters + cnn_pkg::out_rows * cnn_pkg::img_cols
		+ cnn_pkg::pipe_depth + 20;
	// eight passes with double margin, plus reset
	localparam int timeout_ns = (2 * 8 * pass_cycles + 20) * 10;

	logic clk;
	logic rst;
	logic req;
	logic [cnn_pkg::chan_w-1:0] channel;
	logic [cnn_pkg::num_banks-1:0][cnn_pkg::pix_w-1:0] in_rd_data;
	logic [cnn_pkg::wt_word_w-1:0] wt_rd_data;
	logic [cnn_pkg::out_word_w-1:0] out_rd_data;
	logic ack;
	logic in_rd_en;
	logic [cnn_pkg::num_banks-1:0][cnn_pkg::in_addr_w-1:0] in_addr;
	logic wt_rd_en;
	logic [cnn_pkg::wt_addr_w-1:0] wt_addr;
	logic out_rd_en;
	logic [cnn_pkg::out_addr_w-1:0] out_rd_addr;
	logic out_wr_en;
	logic [cnn_pkg::out_addr_w-1:0] out_wr_addr;
	logic [cnn_pkg::out_word_w-1:0] out_wr_data;

	// memory models
	logic [cnn_pkg::pix_w-1:0] in_bank [cnn_pkg::num_banks][1 << cnn_pkg::in_addr_w];
	logic [cnn_pkg::wt_word_w-1:0] wt_mem [1 << cnn_pkg::wt_addr_w];
	logic [cnn_pkg::out_word_w-1:0] out_mem [1 << cnn_pkg::out_addr_w];
	logic [cnn_pkg::num_banks-1:0][cnn_pkg::pix_w-1:0] in_next;
	logic [cnn_pkg::wt_word_w-1:0] wt_next;
	logic [cnn_pkg::out_word_w-1:0] out_next;

	// reference model
	logic signed [cnn_pkg::pix_w-1:0] img [cnn_pkg::img_rows][cnn_pkg::img_cols];
	logic signed [cnn_pkg::pix_w-1:0] wt_tap [1 << cnn_pkg::wt_addr_w][cnn_pkg::num_taps];
	logic signed [cnn_pkg::psum_w-1:0] model_sum [num_pos][cnn_pkg::num_filters];

	int write_count [num_pos];
	int error_count;
	int tests_passed;
	int tests_failed;

	conv_tile_top i_conv_tile_top (
		.clk(clk),
		.rst(rst),
		.req(req),
		.channel(channel),
		.in_rd_data(in_rd_data),
		.wt_rd_data(wt_rd_data),
		.out_rd_data(out_rd_data),
		.ack(ack),
		.in_rd_en(in_rd_en),
		.in_addr(in_addr),
		.wt_rd_en(wt_rd_en),
		.wt_addr(wt_addr),
		.out_rd_en(out_rd_en),
		.out_rd_addr(out_rd_addr),
		.out_wr_en(out_wr_en),
		.out_wr_addr(out_wr_addr),
		.out_wr_data(out_wr_data)
	);

	always #5 clk = ~clk;

	// requests sampled at the edge, read data driven 1 ns later
	always @(posedge clk)
	begin
		in_next = in_rd_data;
		wt_next = wt_rd_data;
		out_next = out_rd_data;
		if (in_rd_en)
		begin
			for (int b = 0; b < cnn_pkg::num_banks; b++)
				in_next[b] = in_bank[b][in_addr[b]];
		end
		if (wt_rd_en)
			wt_next = wt_mem[wt_addr];
		if (out_rd_en)
			out_next = out_mem[out_rd_addr];
		if (out_wr_en)
			out_mem[out_wr_addr] = out_wr_data;
		#1;
		in_rd_data = in_next;
		wt_rd_data = wt_next;
		out_rd_data = out_next;
	end

	// protocol monitor
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (!req && !ack && (in_rd_en || wt_rd_en || out_rd_en || out_wr_en))
			begin
				error_count++;
				$display("memory access while the DUT is idle at %0t", $time);
			end
			if (out_wr_en)
			begin
				if (ack)
				begin
					error_count++;
					$display("output write after ack rose at %0t", $time);
				end
				if (out_wr_addr >= num_pos)
				begin
					error_count++;
					$display("output write outside the tile at %0t", $time);
				end
				else
					write_count[out_wr_addr]++;
			end
		end
	end

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
		begin
			error_count++;
			$display("Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic record_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			tests_passed++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	function automatic logic [cnn_pkg::pix_w-1:0] random_pixel();
		logic [31:0] r;
		r = $urandom();
		return r[cnn_pkg::pix_w-1:0];
	endfunction

	// tap 0 is the top-left weight, in the top bits of the word
	task automatic load_weights();
		for (int a = 0; a < (1 << cnn_pkg::wt_addr_w); a++)
		begin
			for (int t = 0; t < cnn_pkg::num_taps; t++)
			begin
				wt_tap[a][t] = random_pixel();
				wt_mem[a][(cnn_pkg::num_taps - 1 - t) * cnn_pkg::pix_w +: cnn_pkg::pix_w] =
					wt_tap[a][t];
			end
		end
	endtask

	// row r goes to bank r mod 3
	task automatic load_inputs();
		for (int r = 0; r < cnn_pkg::img_rows; r++)
		begin
			for (int c = 0; c < cnn_pkg::img_cols; c++)
			begin
				img[r][c] = random_pixel();
				in_bank[r % cnn_pkg::num_banks][(r / cnn_pkg::num_banks) * cnn_pkg::img_cols + c]
					= img[r][c];
			end
		end
	endtask

	task automatic scramble_outputs();
		for (int a = 0; a < (1 << cnn_pkg::out_addr_w); a++)
		begin
			for (int f = 0; f < cnn_pkg::num_filters; f++)
				out_mem[a][f * cnn_pkg::psum_w +: cnn_pkg::psum_w] = $urandom();
		end
	endtask

	task automatic update_model(input int c);
		logic signed [cnn_pkg::psum_w-1:0] acc;
		int a;
		for (int orow = 0; orow < cnn_pkg::out_rows; orow++)
		begin
			for (int ocol = 0; ocol < cnn_pkg::out_cols; ocol++)
			begin
				a = orow * cnn_pkg::out_cols + ocol;
				for (int f = 0; f < cnn_pkg::num_filters; f++)
				begin
					acc = '0;
					for (int kr = 0; kr < cnn_pkg::kernel_dim; kr++)
					begin
						for (int kc = 0; kc < cnn_pkg::kernel_dim; kc++)
							acc = acc + img[orow + kr][ocol + kc] *
								wt_tap[c * cnn_pkg::num_filters + f][kr * cnn_pkg::kernel_dim + kc];
					end
					if (c == 0)
						model_sum[a][f] = acc;
					else
						model_sum[a][f] = model_sum[a][f] + acc;
				end
			end
		end
	endtask

	// full four-phase handshake, entered 1 ns after an edge
	task automatic run_pass(input int c);
		int cycles;
		for (int a = 0; a < num_pos; a++)
			write_count[a] = 0;
		channel = cnn_pkg::chan_w'(c);
		req = 1'b1;
		cycles = 0;
		@(posedge clk);
		#1;
		while (!ack && cycles < pass_cycles)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!ack)
		begin
			$display("no ack within %0d cycles on channel %0d", pass_cycles, c);
			$display("Testbench failed");
			$finish;
		end
		for (int a = 0; a < num_pos; a++)
			check_value($sformatf("write_count[%0d]", a), write_count[a], 1);
		// ack must hold while req is still high
		repeat (3)
		begin
			@(posedge clk);
			#1;
			check_value("ack", ack, 1'b1);
		end
		req = 1'b0;
		@(posedge clk);
		#1;
		check_value("ack", ack, 1'b0);
		repeat (2)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_outputs();
		logic [cnn_pkg::out_word_w-1:0] exp_word;
		for (int a = 0; a < num_pos; a++)
		begin
			for (int f = 0; f < cnn_pkg::num_filters; f++)
				exp_word[f * cnn_pkg::psum_w +: cnn_pkg::psum_w] = model_sum[a][f];
			check_value($sformatf("out_mem[%0d]", a), out_mem[a], exp_word);
		end
	endtask

	initial
	begin
		int errors_before;
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		channel = '0;
		in_rd_data = '0;
		wt_rd_data = '0;
		out_rd_data = '0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(16));
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		errors_before = error_count;
		repeat (5)
		begin
			@(posedge clk);
			#1;
			check_value("ack", ack, 1'b0);
			check_value("in_rd_en", in_rd_en, 1'b0);
			check_value("wt_rd_en", wt_rd_en, 1'b0);
			check_value("out_rd_en", out_rd_en, 1'b0);
			check_value("out_wr_en", out_wr_en, 1'b0);
		end
		record_test("reset state", errors_before);

		// second run starts over at channel 0 on top of the first run's results
		for (int run = 0; run < 2; run++)
		begin
			load_weights();
			if (run == 0)
				scramble_outputs();
			for (int c = 0; c < cnn_pkg::num_channels; c++)
			begin
				errors_before = error_count;
				load_inputs();
				update_model(c);
				run_pass(c);
				check_outputs();
				record_test($sformatf("run %0d channel %0d", run, c), errors_before);
			end
		end

		$display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(timeout_ns);
		$display("run timed out after %0d ns without finishing", timeout_ns);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
cnn_pkg.sv
scan_control.sv
window_fetch.sv
weight_fetch.sv
mac_array.sv
conv_tile_top.sv
tb_conv_tile.sv
